//--- src.f
cart_pkg.sv
snes_bus_sync.sv
mcu_rom_access.sv
rom_port_mux.sv
cart_main.sv
tb_clock.sv
tb_cart_main.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the cart_main testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_cart_main -f src.f -o tb_cart_main \
  && ./obj_dir/tb_cart_main > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -qx "Test OK" sim.log && exit 0 || exit 1

//--- tb_cart_main.sv
`timescale 1ns/10ps

module tb_cart_main;

  localparam int          dead_timeout  = 300;
  localparam int          rom_cycle_len = 7;
  localparam logic [23:0] mask_value    = 24'h01FFFF;

  localparam int n_pairs    = 20;   // MCU write/read pairs with the SNES dead
  localparam int n_snes_rd  = 16;
  localparam int n_mix_rd   = 10;
  localparam int n_mix_snes = 24;   // Minimum SNES cycles during the mixed phase
  localparam int n_dead_ops = 8;
  localparam int n_ops      = 2 * n_pairs + n_snes_rd + n_mix_rd + n_mix_snes + n_dead_ops;
  localparam int rdy_limit  = dead_timeout + 100;

  typedef struct packed {
    logic            is_read;
    cart_pkg::byte_t expected;
  } access_t;

  logic                             CLK2;
  logic                             reset;
  logic [cart_pkg::snes_addr_w-1:0] snes_addr;
  logic                             snes_read_n;
  logic                             snes_cpu_clk;
  logic                             snes_rd_cs_n;
  cart_pkg::byte_t                  snes_rdata;
  logic                             snes_data_oe;
  cart_pkg::mcu_req_t               mcu_req;
  logic                             mcu_rdy;
  cart_pkg::byte_t                  mcu_rdata;
  cart_pkg::rom_bus_t               rom;
  cart_pkg::word_t                  rom_dout;
  logic                             rom_dout_en;
  cart_pkg::word_t                  rom_din;
  logic [cart_pkg::snes_addr_w-1:0] rom_mask;

  cart_pkg::word_t psram  [65536];
  cart_pkg::word_t shadow [65536];   // Expected memory contents
  access_t         op_queue [$];

  int   seed         = 32'h4cb7;
  int   mismatch_cnt = 0;
  int   fail_cnt     = 0;
  logic mix_done;

  tb_clock i_clock (
    .CLK2 (CLK2),
    .reset(reset)
  );

  cart_main #(
    .dead_timeout (dead_timeout),
    .rom_cycle_len(rom_cycle_len)
  ) i_dut (
    .CLK2        (CLK2),
    .reset       (reset),
    .snes_addr   (snes_addr),
    .snes_read_n (snes_read_n),
    .snes_cpu_clk(snes_cpu_clk),
    .snes_rd_cs_n(snes_rd_cs_n),
    .snes_rdata  (snes_rdata),
    .snes_data_oe(snes_data_oe),
    .mcu_req     (mcu_req),
    .mcu_rdy     (mcu_rdy),
    .mcu_rdata   (mcu_rdata),
    .rom         (rom),
    .rom_dout    (rom_dout),
    .rom_dout_en (rom_dout_en),
    .rom_din     (rom_din),
    .rom_mask    (rom_mask)
  );

  ////////////////////////////////////////
  // Helpers and reference model
  ////////////////////////////////////////
  function automatic cart_pkg::word_t fill_word(input int idx);
    return cart_pkg::word_t'((idx * 40503) ^ (idx >> 6) ^ 32'h0000a5c3);
  endfunction

  // Odd byte address is the low lane
  function automatic cart_pkg::byte_t expected_byte(input logic [23:0] addr,
                                                    input logic [23:0] mask);
    logic [23:0]     mapped;
    cart_pkg::word_t w;
    mapped = addr & mask;
    w = shadow[mapped[16:1]];
    if (mapped[0]) return w[7:0];
    return w[15:8];
  endfunction

  task automatic write_shadow(input logic [23:0] addr, input cart_pkg::byte_t data);
    if (addr[0]) begin
      shadow[addr[16:1]][7:0] = data;
    end else begin
      shadow[addr[16:1]][15:8] = data;
    end
  endtask

  function automatic logic [23:0] rand_mcu_addr();
    return 24'($random(seed)) & 24'h01FFFF;   // Inside the 64K word model
  endfunction

  function automatic logic [23:0] rand_snes_addr();
    return 24'($random(seed)) | 24'h400000;   // Bit 22 selects ROM
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      mismatch_cnt++;
    end
  endtask

  ////////////////////////////////////////
  // PSRAM model
  ////////////////////////////////////////
  always @(posedge CLK2) begin
    if (reset) begin
      for (int i = 0; i < 65536; i++) begin
        psram[i] <= fill_word(i);
      end
    end else if (!rom.we_n) begin
      check_value("rom_dout_en", 32'(rom_dout_en), 32'd1);   // Data driven with the strobe
      if (!rom.ble_n) psram[rom.addr[15:0]][7:0] <= rom_dout[7:0];
      if (!rom.bhe_n) psram[rom.addr[15:0]][15:8] <= rom_dout[15:8];
    end
  end

  assign rom_din = psram[rom.addr[15:0]];   // Answers in the same cycle

  ////////////////////////////////////////
  // Bus drivers
  ////////////////////////////////////////
  task automatic mcu_access(input logic is_read, input logic [23:0] addr,
                            input cart_pkg::byte_t data, output int latency);
    cart_pkg::mcu_req_t req_v;
    access_t            op;
    latency = 0;
    while (!mcu_rdy) @(negedge CLK2);
    req_v.rrq   = is_read;
    req_v.wrq   = ~is_read;
    req_v.addr  = addr;
    req_v.wdata = data;
    op.is_read  = is_read;
    op.expected = expected_byte(addr, '1);
    @(posedge CLK2);
    mcu_req <= req_v;
    op_queue.push_back(op);
    if (!is_read) write_shadow(addr, data);
    @(posedge CLK2);
    mcu_req <= '0;
    @(negedge CLK2);
    check_value("mcu_rdy", 32'(mcu_rdy), 32'd0);   // Busy right after the request
    while (!mcu_rdy && latency < rdy_limit) begin
      @(negedge CLK2);
      latency++;
    end
    if (!mcu_rdy) begin
      $display("Error: mcu_rdy did not return within %0d cycles", rdy_limit);
      fail_cnt++;
    end
  endtask

  // One SNES cycle of 6 low and 6 high with the read strobe in the high phase
  task automatic snes_cycle(input logic [23:0] addr);
    @(posedge CLK2);
    snes_cpu_clk <= 1'b0;
    snes_addr    <= addr;
    snes_rd_cs_n <= 1'b0;
    repeat (6) @(posedge CLK2);
    snes_cpu_clk <= 1'b1;
    @(posedge CLK2);
    snes_read_n <= 1'b0;
    repeat (4) @(posedge CLK2);
    snes_read_n <= 1'b1;
    @(negedge CLK2);   // End of the filtered read phase
    check_value("snes_data_oe", 32'(snes_data_oe), 32'd1);
    check_value("snes_rdata", 32'(snes_rdata), 32'(expected_byte(addr, mask_value)));
  endtask

  task automatic snes_idle();
    @(posedge CLK2);
    snes_cpu_clk <= 1'b0;
    snes_rd_cs_n <= 1'b1;
    snes_read_n  <= 1'b1;
  endtask

  ////////////////////////////////////////
  // MCU read data compare
  ////////////////////////////////////////
  initial begin : rdata_compare
    logic    rdy_q;
    access_t op;
    rdy_q = 1'b1;
    forever begin
      @(negedge CLK2);
      if (!reset && mcu_rdy && !rdy_q) begin
        if (op_queue.size() == 0) begin
          $display("Error: mcu_rdy rose with no request outstanding");
          fail_cnt++;
        end else begin
          op = op_queue.pop_front();
          if (op.is_read) check_value("mcu_rdata", 32'(mcu_rdata), 32'(op.expected));
        end
      end
      rdy_q = mcu_rdy;
    end
  end

  initial begin : watchdog
    #(n_ops * 2000);
    $display("Error: watchdog expired after %0d ns", n_ops * 2000);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt + 1);
    $display("Test FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial begin : main_seq
    logic [23:0] addr_list [n_pairs];
    logic [23:0] addr;
    int          lat;
    snes_addr    <= '0;
    snes_read_n  <= 1'b1;
    snes_cpu_clk <= 1'b0;
    snes_rd_cs_n <= 1'b1;
    mcu_req      <= '0;
    rom_mask     <= mask_value;
    mix_done     = 1'b0;
    for (int i = 0; i < 65536; i++) begin
      shadow[i] = fill_word(i);
    end
    @(negedge reset);
    @(negedge CLK2);

    // Idle outputs after reset
    check_value("mcu_rdy", 32'(mcu_rdy), 32'd1);
    check_value("rom.we_n", 32'(rom.we_n), 32'd1);
    check_value("rom_dout_en", 32'(rom_dout_en), 32'd0);
    check_value("snes_data_oe", 32'(snes_data_oe), 32'd0);

    // MCU goes straight through while the SNES is dead
    for (int i = 0; i < n_pairs; i++) begin
      addr_list[i] = rand_mcu_addr();
      mcu_access(1'b0, addr_list[i], 8'($random(seed)), lat);
    end
    for (int i = 0; i < n_pairs; i++) begin
      mcu_access(1'b1, addr_list[i], 8'h00, lat);
    end

    for (int i = 0; i < n_snes_rd; i++) begin
      snes_cycle(rand_snes_addr());
    end

    // MCU reads slotted between SNES ROM reads
    fork
      begin : mcu_branch
        for (int k = 0; k < n_mix_rd; k++) begin
          mcu_access(1'b1, rand_mcu_addr(), 8'h00, lat);
        end
        mix_done = 1'b1;
      end
      begin : snes_branch
        int n;
        n = 0;
        while (!mix_done || n < n_mix_snes) begin
          snes_cycle(rand_snes_addr());
          n++;
        end
      end
    join

    // Pending read waits for the dead timeout
    snes_idle();
    repeat (10) @(posedge CLK2);
    mcu_access(1'b1, rand_mcu_addr(), 8'h00, lat);
    if (lat < dead_timeout - 20) begin
      $display("Error: MCU read finished after %0d cycles, before the SNES was dead", lat);
      fail_cnt++;
    end
    addr = rand_mcu_addr();
    mcu_access(1'b0, addr, 8'($random(seed)), lat);
    mcu_access(1'b1, addr, 8'h00, lat);

    // SNES comes back while the read is in its address phase
    fork
      begin : revive_snes
        repeat (4) snes_cycle(rand_snes_addr());
      end
      begin : revive_mcu
        int rlat;
        repeat (4) @(posedge CLK2);
        mcu_access(1'b1, rand_mcu_addr(), 8'h00, rlat);
        if (rlat <= rom_cycle_len + 4) begin
          $display("Error: MCU read was not restarted when the SNES revived");
          fail_cnt++;
        end
      end
    join
    snes_idle();
    repeat (4) @(negedge CLK2);

    if (op_queue.size() != 0) begin
      $display("Error: %0d MCU accesses never completed", op_queue.size());
      fail_cnt++;
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
  parameter int half_period  = 10,
  parameter int reset_cycles = 4
) (
  output logic CLK2,
  output logic reset
);

  initial begin
    CLK2 = 1'b0;
    forever #(half_period) CLK2 = ~CLK2;
  end

  // Synchronous reset, released on a rising edge
  initial begin
    reset <= 1'b1;
    repeat (reset_cycles) @(posedge CLK2);
    reset <= 1'b0;
  end

endmodule

//--- cart_main.sv
`timescale 1ns/10ps

module cart_main #(
  parameter int dead_timeout  = 88000,
  parameter int rom_cycle_len = 7
) (
  input  logic                             CLK2,
  input  logic                             reset,
  // SNES side
  input  logic [cart_pkg::snes_addr_w-1:0] snes_addr,
  input  logic                             snes_read_n,
  input  logic                             snes_cpu_clk,
  input  logic                             snes_rd_cs_n,
  output cart_pkg::byte_t                  snes_rdata,
  output logic                             snes_data_oe,
  // MCU side
  input  cart_pkg::mcu_req_t               mcu_req,
  output logic                             mcu_rdy,
  output cart_pkg::byte_t                  mcu_rdata,
  // PSRAM side
  output cart_pkg::rom_bus_t               rom,
  output cart_pkg::word_t                  rom_dout,
  output logic                             rom_dout_en,
  input  cart_pkg::word_t                  rom_din,
  input  logic [cart_pkg::snes_addr_w-1:0] rom_mask
);

  cart_pkg::snes_bus_t snes_bus;
  cart_pkg::mcu_port_t mcu_port;
  logic                rom_hit;
  cart_pkg::byte_t     rom_byte;

  snes_bus_sync #(
    .dead_timeout(dead_timeout)
  ) i_sync (
    .CLK2        (CLK2),
    .reset       (reset),
    .snes_addr   (snes_addr),
    .snes_read_n (snes_read_n),
    .snes_cpu_clk(snes_cpu_clk),
    .rom_hit     (rom_hit),
    .bus         (snes_bus)
  );

  mcu_rom_access #(
    .rom_cycle_len(rom_cycle_len)
  ) i_access (
    .CLK2    (CLK2),
    .reset   (reset),
    .req     (mcu_req),
    .bus     (snes_bus),
    .rom_byte(rom_byte),
    .port    (mcu_port),
    .rdy     (mcu_rdy),
    .rdata   (mcu_rdata)
  );

  rom_port_mux i_port (
    .bus         (snes_bus),
    .port        (mcu_port),
    .rom_mask    (rom_mask),
    .snes_rd_cs_n(snes_rd_cs_n),
    .rom_din     (rom_din),
    .rom         (rom),
    .rom_dout    (rom_dout),
    .rom_dout_en (rom_dout_en),
    .rom_hit     (rom_hit),
    .rom_byte    (rom_byte),
    .snes_rdata  (snes_rdata),
    .snes_data_oe(snes_data_oe)
  );

endmodule

//--- rom_port_mux.sv
`timescale 1ns/10ps

module rom_port_mux (
  input  cart_pkg::snes_bus_t              bus,
  input  cart_pkg::mcu_port_t              port,
  input  logic [cart_pkg::snes_addr_w-1:0] rom_mask,
  input  logic                             snes_rd_cs_n,
  input  cart_pkg::word_t                  rom_din,
  output cart_pkg::rom_bus_t               rom,
  output cart_pkg::word_t                  rom_dout,
  output logic                             rom_dout_en,
  output logic                             rom_hit,
  output cart_pkg::byte_t                  rom_byte,
  output cart_pkg::byte_t                  snes_rdata,
  output logic                             snes_data_oe
);

  logic [cart_pkg::snes_addr_w-1:0] snes_mapped;
  logic [cart_pkg::snes_addr_w-1:0] sel_addr;
  logic                             lane;
  logic                             mcu_wr;

  ////////////////////////////////////////
  // Address mapping and source select
  ////////////////////////////////////////
  assign rom_hit     = bus.addr[22];
  assign snes_mapped = bus.addr & rom_mask;

  // MCU wins only while the FSM sits in an address state
  assign sel_addr = port.active ? port.addr : snes_mapped;
  assign lane     = sel_addr[0];   // 1 = low byte

  assign rom.addr  = sel_addr[cart_pkg::snes_addr_w-1:1];
  assign rom.bhe_n = lane;
  assign rom.ble_n = ~lane;

  ////////////////////////////////////////
  // Write path
  ////////////////////////////////////////
  assign mcu_wr = port.active & port.writing;

  assign rom.we_n    = ~mcu_wr;
  assign rom_dout    = {port.wdata, port.wdata};   // Lane enables pick the half
  assign rom_dout_en = mcu_wr;

  ////////////////////////////////////////
  // Read path
  ////////////////////////////////////////
  always_comb begin
    if (lane) begin
      rom_byte = rom_din[7:0];
    end else begin
      rom_byte = rom_din[15:8];
    end
  end

  assign snes_rdata   = rom_byte;
  assign snes_data_oe = ~bus.read_n & rom_hit & ~snes_rd_cs_n;   // ROM reads only

endmodule

//--- mcu_rom_access.sv
`timescale 1ns/10ps

module mcu_rom_access #(
  parameter int rom_cycle_len = 7
) (
  input  logic                CLK2,
  input  logic                reset,
  input  cart_pkg::mcu_req_t  req,
  input  cart_pkg::snes_bus_t bus,
  input  cart_pkg::byte_t     rom_byte,
  output cart_pkg::mcu_port_t port,
  output logic                rdy,
  output cart_pkg::byte_t     rdata
);

  localparam int dly_w = $clog2(rom_cycle_len + 2);

  cart_pkg::mcu_state_t state;

  logic [dly_w-1:0]                 mem_dly;
  logic                             rd_pend;
  logic                             wr_pend;
  logic [cart_pkg::snes_addr_w-1:0] addr_r;
  cart_pkg::byte_t                  wdata_r;

  logic at_end;
  logic revive;

  assign at_end = (state == cart_pkg::rd_end) || (state == cart_pkg::wr_end);
  // Still flagged dead while the clock is already back
  assign revive = bus.dead & bus.cpu_clk;

  ////////////////////////////////////////
  // Request capture
  ////////////////////////////////////////
  always_ff @(posedge CLK2) begin
    if (reset) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy     <= 1'b1;
    end else if (req.rrq && rdy) begin
      rd_pend <= 1'b1;
      rdy     <= 1'b0;
    end else if (req.wrq && rdy) begin
      wr_pend <= 1'b1;
      rdy     <= 1'b0;
    end else if (at_end) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy     <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if ((req.rrq || req.wrq) && rdy) begin
      addr_r  <= req.addr;
      wdata_r <= req.wdata;   // Don't care on reads
    end
  end

  ////////////////////////////////////////
  // Access FSM
  ////////////////////////////////////////
  always_ff @(posedge CLK2) begin
    if (reset) begin
      state   <= cart_pkg::idle;
      mem_dly <= '0;
    end else if (revive) begin
      state <= cart_pkg::idle;   // Restart, request stays pending
    end else begin
      case (state)
        cart_pkg::idle: begin
          if (bus.free_slot || bus.dead) begin
            if (rd_pend) begin
              state   <= cart_pkg::rd_addr;
              mem_dly <= dly_w'(rom_cycle_len);
            end else if (wr_pend) begin
              state   <= cart_pkg::wr_addr;
              mem_dly <= dly_w'(rom_cycle_len);
            end
          end
        end
        cart_pkg::rd_addr: begin
          mem_dly <= mem_dly - 1'b1;
          if (mem_dly == '0) state <= cart_pkg::rd_end;
        end
        cart_pkg::wr_addr: begin
          mem_dly <= mem_dly - 1'b1;
          if (mem_dly == '0) state <= cart_pkg::wr_end;
        end
        default: begin
          state <= cart_pkg::idle;   // Both end states
        end
      endcase
    end
  end

  // Last sample before rd_end is the one handed back
  always_ff @(posedge CLK2) begin
    if (state == cart_pkg::rd_addr) rdata <= rom_byte;
  end

  assign port.active  = (state == cart_pkg::rd_addr) || (state == cart_pkg::wr_addr);
  assign port.writing = (state == cart_pkg::wr_addr);
  assign port.addr    = addr_r;
  assign port.wdata   = wdata_r;

endmodule

//--- snes_bus_sync.sv
`timescale 1ns/10ps

module snes_bus_sync #(
  parameter int dead_timeout = 88000
) (
  input  logic                             CLK2,
  input  logic                             reset,
  input  logic [cart_pkg::snes_addr_w-1:0] snes_addr,
  input  logic                             snes_read_n,
  input  logic                             snes_cpu_clk,
  input  logic                             rom_hit,
  output cart_pkg::snes_bus_t              bus
);

  // Saturates one above the timeout
  localparam int cnt_w = $clog2(dead_timeout + 2);

  logic [7:0]                       read_r;
  logic [5:0]                       clk_r;
  logic [cart_pkg::snes_addr_w-1:0] addr_r [4];

  logic             free_strobe;
  logic [cnt_w-1:0] dead_cnt;
  logic             dead;

  logic cpu_clk_lvl;
  logic cycle_start;
  logic cycle_end;

  ////////////////////////////////////////
  // Input shift chains
  ////////////////////////////////////////
  always_ff @(posedge CLK2) begin
    if (reset) begin
      read_r <= '1;   // Idle bus reads high
      clk_r  <= '0;
    end else begin
      read_r <= {read_r[6:0], snes_read_n};
      clk_r  <= {clk_r[4:0], snes_cpu_clk};
    end
  end

  always_ff @(posedge CLK2) begin
    addr_r[0] <= snes_addr;
    addr_r[1] <= addr_r[0];
    addr_r[2] <= addr_r[1];
    addr_r[3] <= addr_r[2];
  end

  // A single high sample between lows is treated as a glitch
  assign cpu_clk_lvl = clk_r[2] & clk_r[1];

  ////////////////////////////////////////
  // Cycle edge patterns
  ////////////////////////////////////////
  assign cycle_start = ((clk_r[4:1] & clk_r[5:2]) == 4'b0001);
  assign cycle_end   = ((clk_r[4:1] & clk_r[5:2]) == 4'b1110);

  // Second slot in the cycle, only free when the SNES is not on ROM
  always_ff @(posedge CLK2) begin
    if (reset) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= cycle_start & ~rom_hit;
    end
  end

  ////////////////////////////////////////
  // Dead time detection
  ////////////////////////////////////////
  always_ff @(posedge CLK2) begin
    if (reset) begin
      dead_cnt <= '0;
    end else if (cpu_clk_lvl) begin
      dead_cnt <= '0;
    end else if (dead_cnt <= cnt_w'(dead_timeout)) begin
      dead_cnt <= dead_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (reset) begin
      dead <= 1'b1;   // No SNES seen yet
    end else if (cpu_clk_lvl) begin
      dead <= 1'b0;
    end else if (dead_cnt > cnt_w'(dead_timeout)) begin
      dead <= 1'b1;
    end
  end

  assign bus.addr        = addr_r[3] & addr_r[2];
  assign bus.read_n      = read_r[2] & read_r[1];
  assign bus.cpu_clk     = cpu_clk_lvl;
  assign bus.cycle_start = cycle_start;
  assign bus.cycle_end   = cycle_end;
  assign bus.rd_start    = ((read_r[6:1] & read_r[7:2]) == 6'b111110);
  assign bus.free_slot   = cycle_end | free_strobe;
  assign bus.dead        = dead;

endmodule

//--- cart_pkg.sv
package cart_pkg;

  ////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////
  localparam int snes_addr_w = 24;
  localparam int rom_addr_w  = 23;   // 16-bit words, so one bit less

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] word_t;

  // Filtered SNES status, all in the CLK2 domain
  typedef struct packed {
    logic [snes_addr_w-1:0] addr;
    logic                   read_n;
    logic                   cpu_clk;
    logic                   cycle_start;
    logic                   cycle_end;
    logic                   rd_start;
    logic                   free_slot;   // MCU may take the PSRAM now
    logic                   dead;
  } snes_bus_t;

  // One-cycle request from the MCU
  typedef struct packed {
    logic                   rrq;
    logic                   wrq;
    logic [snes_addr_w-1:0] addr;
    byte_t                  wdata;
  } mcu_req_t;

  typedef struct packed {
    logic                   active;    // MCU owns the PSRAM address
    logic                   writing;
    logic [snes_addr_w-1:0] addr;
    byte_t                  wdata;
  } mcu_port_t;

  // PSRAM control lines, all active low except addr
  typedef struct packed {
    logic [rom_addr_w-1:0] addr;
    logic                  we_n;
    logic                  bhe_n;
    logic                  ble_n;
  } rom_bus_t;

  typedef enum logic [4:0] {
    idle    = 5'b00001,
    rd_addr = 5'b00010,
    rd_end  = 5'b00100,
    wr_addr = 5'b01000,
    wr_end  = 5'b10000
  } mcu_state_t;

endpackage
